// File: design/word_lookup_settings.svh
`ifndef WORD_LOOKUP_SETTINGS_SVH
`define WORD_LOOKUP_SETTINGS_SVH

// memory geometry, each memory holds 2**WL_ADDR_WIDTH characters
`define WL_ADDR_WIDTH      8
`define WL_DATA_WIDTH      8
`define WL_AXI_ADDR_WIDTH  12
`define WL_CYCLE_WIDTH     16
`define WL_DEFAULT_LIMIT   16'd4096

// register map, one 32-bit word per register
`define WL_REG_CTRL        12'h000
`define WL_REG_STATUS      12'h004
`define WL_REG_VOCAB_END   12'h008
`define WL_REG_INPUT_START 12'h00C
`define WL_REG_CYCLES      12'h010
`define WL_REG_MATCH_ADDR  12'h014
`define WL_REG_LIMIT       12'h018

// byte windows, one character in the low byte of each 32-bit word
`define WL_VOCAB_BASE      12'h400
`define WL_INPUT_BASE      12'h800

`endif

// File: design/word_lookup_pkg.sv
`include "word_lookup_settings.svh"

package word_lookup_pkg;

    typedef logic [`WL_ADDR_WIDTH-1:0] wl_addr_t;
    typedef logic [`WL_DATA_WIDTH-1:0] wl_char_t;

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        COMPARE,
        ADVANCE,
        SKIP_FETCH,
        SKIP,
        FOUND,
        NOT_FOUND,
        ERROR
    } wl_state_t;

endpackage

// File: design/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic                      clk,
    input  logic                      we,
    input  word_lookup_pkg::wl_addr_t waddr,
    input  word_lookup_pkg::wl_char_t wdata,
    input  word_lookup_pkg::wl_addr_t raddr,
    output word_lookup_pkg::wl_char_t rdata
);
    import word_lookup_pkg::*;

    localparam int DEPTH = 2 ** $bits(wl_addr_t);

    wl_char_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: design/scan_timer.sv
`timescale 1ns/1ps
`include "word_lookup_settings.svh"

module scan_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       scan_active,
    input  logic [`WL_CYCLE_WIDTH-1:0] limit,
    output logic [`WL_CYCLE_WIDTH-1:0] cycles,
    output logic                       expired
);

    logic at_limit;
    logic at_max;

    assign at_limit = (cycles == limit);
    assign at_max   = &cycles;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles  <= '0;
            expired <= 1'b0;
        end else if (start) begin
            cycles  <= '0;
            expired <= 1'b0;
        end else begin
            // holds at the limit, saturates if the limit was lowered mid-scan
            if (scan_active && !at_limit && !at_max) begin
                cycles <= cycles + 1'b1;
            end
            expired <= scan_active && at_limit;
        end
    end

    // the matcher must still be scanning when expiry shows up
    a_expire_in_scan: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(expired) |-> scan_active
    );

endmodule

// File: design/match_fsm.sv
`timescale 1ns/1ps

module match_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      clear,
    input  word_lookup_pkg::wl_addr_t vocab_end,
    input  word_lookup_pkg::wl_addr_t input_start,
    input  word_lookup_pkg::wl_char_t vocab_rdata,
    input  word_lookup_pkg::wl_char_t input_rdata,
    input  logic                      expired,
    output word_lookup_pkg::wl_addr_t vocab_raddr,
    output word_lookup_pkg::wl_addr_t input_raddr,
    output logic                      scan_active,
    output logic                      busy,
    output logic                      done,
    output logic                      found,
    output logic                      error,
    output word_lookup_pkg::wl_addr_t match_addr
);
    import word_lookup_pkg::*;

    wl_state_t state;
    wl_addr_t  va;
    wl_addr_t  ia;
    wl_addr_t  end_q;
    wl_addr_t  start_q;
    logic      at_entry;

    // query pointer still on its first character
    assign at_entry    = (ia == start_q);
    assign vocab_raddr = va;
    assign input_raddr = ia;

    assign busy        = !(state inside {IDLE, FOUND, NOT_FOUND, ERROR});
    assign scan_active = busy;
    assign done        = (state == FOUND) || (state == NOT_FOUND);
    assign found       = (state == FOUND);
    assign error       = (state == ERROR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            va         <= '0;
            ia         <= '0;
            end_q      <= '0;
            start_q    <= '0;
            match_addr <= '0;
        end else if (busy && expired) begin
            state <= ERROR;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        va         <= '0;
                        ia         <= input_start;
                        end_q      <= vocab_end;
                        start_q    <= input_start;
                        match_addr <= '0;
                        state      <= FETCH;
                    end
                end
                // addresses are on the RAM ports, data arrives in COMPARE
                FETCH: begin
                    state <= (va == end_q) ? NOT_FOUND : COMPARE;
                end
                COMPARE: begin
                    if (at_entry && input_rdata == '0) begin
                        // empty query
                        state <= NOT_FOUND;
                    end else if (vocab_rdata == input_rdata) begin
                        state <= (vocab_rdata == '0) ? FOUND : ADVANCE;
                    end else begin
                        // also covers an empty entry, its zero is seen in SKIP
                        state <= SKIP_FETCH;
                    end
                end
                ADVANCE: begin
                    va    <= va + 1'b1;
                    ia    <= ia + 1'b1;
                    state <= FETCH;
                end
                SKIP_FETCH: begin
                    state <= (va == end_q) ? NOT_FOUND : SKIP;
                end
                SKIP: begin
                    va <= va + 1'b1;
                    if (vocab_rdata == '0) begin
                        ia         <= start_q;
                        match_addr <= va + 1'b1;
                        state      <= FETCH;
                    end else begin
                        state <= SKIP_FETCH;
                    end
                end
                FOUND, NOT_FOUND, ERROR: begin
                    if (clear) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a found entry always starts below the end address
    a_found_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) found |-> (match_addr < end_q)
    );

    a_error_on_expiry: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(error) |-> $past(expired)
    );

    a_final_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {FOUND, NOT_FOUND, ERROR}) && !clear |=> $stable(state)
    );

endmodule

// File: design/axil_regs.sv
`timescale 1ns/1ps
`include "word_lookup_settings.svh"

module axil_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`WL_AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`WL_AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic                          busy,
    input  logic                          done,
    input  logic                          found,
    input  logic                          error,
    input  word_lookup_pkg::wl_addr_t     match_addr,
    input  logic [`WL_CYCLE_WIDTH-1:0]    cycles,
    output logic                          start,
    output logic                          clear,
    output word_lookup_pkg::wl_addr_t     vocab_end,
    output word_lookup_pkg::wl_addr_t     input_start,
    output logic [`WL_CYCLE_WIDTH-1:0]    limit,
    output logic                          vocab_we,
    output word_lookup_pkg::wl_addr_t     vocab_waddr,
    output word_lookup_pkg::wl_char_t     vocab_wdata,
    output logic                          input_we,
    output word_lookup_pkg::wl_addr_t     input_waddr,
    output word_lookup_pkg::wl_char_t     input_wdata
);
    import word_lookup_pkg::*;

    // window index bits sit above the byte offset of each word
    localparam int         WIN_LSB     = $bits(wl_addr_t) + 2;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_accept;
    logic        rd_fire;
    logic        in_vocab;
    logic        in_input;
    logic [31:0] rd_word;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign rd_fire = arready && arvalid;
    assign rresp   = RESP_OKAY;

    assign in_vocab = (awaddr >> WIN_LSB) == (`WL_VOCAB_BASE >> WIN_LSB);
    assign in_input = (awaddr >> WIN_LSB) == (`WL_INPUT_BASE >> WIN_LSB);

    // window writes are dropped while a scan reads the memories
    assign vocab_we    = wr_accept && in_vocab && !busy;
    assign vocab_waddr = awaddr[WIN_LSB-1:2];
    assign vocab_wdata = wdata[`WL_DATA_WIDTH-1:0];
    assign input_we    = wr_accept && in_input && !busy;
    assign input_waddr = awaddr[WIN_LSB-1:2];
    assign input_wdata = wdata[`WL_DATA_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_accept   <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= RESP_OKAY;
            start       <= 1'b0;
            clear       <= 1'b0;
            vocab_end   <= '0;
            input_start <= '0;
            limit       <= `WL_DEFAULT_LIMIT;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            start     <= 1'b0;
            clear     <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_accept) begin
                bvalid <= 1'b1;
                bresp  <= (busy && (in_vocab || in_input)) ? RESP_SLVERR : RESP_OKAY;
                case (awaddr)
                    `WL_REG_CTRL: begin
                        // start only from an idle matcher
                        start <= wdata[0] && !busy && !done && !error;
                        clear <= wdata[1];
                    end
                    `WL_REG_VOCAB_END:   vocab_end   <= wdata[`WL_ADDR_WIDTH-1:0];
                    `WL_REG_INPUT_START: input_start <= wdata[`WL_ADDR_WIDTH-1:0];
                    `WL_REG_LIMIT:       limit       <= wdata[`WL_CYCLE_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (araddr)
            `WL_REG_STATUS:      rd_word[3:0] = {error, found, done, busy};
            `WL_REG_VOCAB_END:   rd_word[`WL_ADDR_WIDTH-1:0] = vocab_end;
            `WL_REG_INPUT_START: rd_word[`WL_ADDR_WIDTH-1:0] = input_start;
            `WL_REG_CYCLES:      rd_word[`WL_CYCLE_WIDTH-1:0] = cycles;
            `WL_REG_MATCH_ADDR:  rd_word[`WL_ADDR_WIDTH-1:0] = match_addr;
            `WL_REG_LIMIT:       rd_word[`WL_CYCLE_WIDTH-1:0] = limit;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid
    );

endmodule

// File: design/word_lookup_top.sv
`timescale 1ns/1ps
`include "word_lookup_settings.svh"

module word_lookup_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`WL_AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`WL_AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready
);
    import word_lookup_pkg::*;

    logic                       start;
    logic                       clear;
    logic                       busy;
    logic                       done;
    logic                       found;
    logic                       error;
    logic                       scan_active;
    logic                       expired;
    logic                       vocab_we;
    logic                       input_we;
    logic [`WL_CYCLE_WIDTH-1:0] limit;
    logic [`WL_CYCLE_WIDTH-1:0] cycles;
    wl_addr_t                   vocab_end;
    wl_addr_t                   input_start;
    wl_addr_t                   match_addr;
    wl_addr_t                   vocab_waddr;
    wl_addr_t                   input_waddr;
    wl_addr_t                   vocab_raddr;
    wl_addr_t                   input_raddr;
    wl_char_t                   vocab_wdata;
    wl_char_t                   input_wdata;
    wl_char_t                   vocab_rdata;
    wl_char_t                   input_rdata;

    axil_regs i_axil_regs (.*);

    word_ram i_vocab_ram (
        .clk   (clk),
        .we    (vocab_we),
        .waddr (vocab_waddr),
        .wdata (vocab_wdata),
        .raddr (vocab_raddr),
        .rdata (vocab_rdata)
    );

    word_ram i_input_ram (
        .clk   (clk),
        .we    (input_we),
        .waddr (input_waddr),
        .wdata (input_wdata),
        .raddr (input_raddr),
        .rdata (input_rdata)
    );

    match_fsm i_match_fsm (.*);

    scan_timer i_scan_timer (.*);

endmodule

// File: testbench/tb_word_lookup.sv
`timescale 1ns/1ps
`include "word_lookup_settings.svh"

module tb_word_lookup;
    import word_lookup_pkg::*;

    localparam realtime CLK_PERIOD  = 100;
    localparam int      N_TESTS     = 54;
    // register traffic and window loads per test, on top of the scan itself
    localparam int      LOAD_CYCLES = 2000;
    localparam realtime WATCHDOG    = N_TESTS * (`WL_DEFAULT_LIMIT + LOAD_CYCLES) * CLK_PERIOD;

    logic                          clk;
    logic                          rst_n;
    logic [`WL_AXI_ADDR_WIDTH-1:0] awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [31:0]                   wdata;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`WL_AXI_ADDR_WIDTH-1:0] araddr;
    logic                          arvalid;
    logic                          arready;
    logic [31:0]                   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;

    logic [31:0] lcg_state = 32'haa232665;
    wl_char_t    vocab_img [256];
    wl_char_t    query_img [256];
    int          entry_start [256];
    int          n_entries;
    int          vend;
    int          qstart;
    logic [31:0] cur_limit;
    int          checks;
    int          value_errors;
    int          resp_errors;
    string       cur_label;
    bit          exp_found;
    bit          exp_error;
    int          exp_addr;
    logic [31:0] got_status;
    logic [31:0] got_maddr;
    logic [31:0] got_cycles;
    event        result_ready;
    event        compare_done;

    word_lookup_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    // '.' stands for the terminating zero in string images
    function automatic wl_char_t char_of(input byte c);
        return (c == ".") ? 8'h00 : wl_char_t'(c);
    endfunction

    function automatic logic [`WL_AXI_ADDR_WIDTH-1:0] win_addr(
            input logic [`WL_AXI_ADDR_WIDTH-1:0] base, input int idx);
        return base | {2'b00, wl_addr_t'(idx), 2'b00};
    endfunction

    // entry by entry: an entry counts only if its zero lies below the end address
    function automatic bit word_lookup_ref(input wl_char_t vocab [256], input int end_addr,
            input wl_char_t query [256], input int start, output int entry);
        int s;
        int k;
        entry = 0;
        if (query[start % 256] == 8'h00) begin
            return 1'b0;
        end
        s = 0;
        while (s < end_addr) begin
            k = 0;
            while (s + k < end_addr && vocab[s + k] != 8'h00
                   && vocab[s + k] == query[(start + k) % 256]) begin
                k++;
            end
            if (s + k >= end_addr) begin
                return 1'b0;
            end
            if (vocab[s + k] == 8'h00 && query[(start + k) % 256] == 8'h00) begin
                entry = s;
                return 1'b1;
            end
            while (s + k < end_addr && vocab[s + k] != 8'h00) begin
                k++;
            end
            s = s + k + 1;
        end
        return 1'b0;
    endfunction

    task automatic axi_write(input logic [`WL_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
            output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [`WL_AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
        check_resp("register read", resp, 2'b00);
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR %0t: %s answered %b, expected %b", $time, what, got, exp);
            resp_errors++;
        end
    endtask

    task automatic write_reg(input logic [`WL_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp("register write", resp, 2'b00);
    endtask

    task automatic put_byte(input bit to_query, input int idx, input wl_char_t c);
        logic [1:0] resp;
        if (to_query) begin
            query_img[idx % 256] = c;
            axi_write(win_addr(`WL_INPUT_BASE, idx), {24'h0, c}, resp);
        end else begin
            vocab_img[idx % 256] = c;
            axi_write(win_addr(`WL_VOCAB_BASE, idx), {24'h0, c}, resp);
        end
        check_resp("window write", resp, 2'b00);
    endtask

    task automatic load_str(input bit to_query, input string s, input int at);
        for (int i = 0; i < s.len(); i++) begin
            put_byte(to_query, at + i, char_of(s[i]));
        end
        if (to_query) begin
            qstart = at;
        end else begin
            vend = at + s.len();
        end
    endtask

    // letters a to c only, so prefixes collide often
    task automatic put_word(input bit to_query, input int at, output int len);
        len = 1 + rand_below(6);
        for (int i = 0; i < len; i++) begin
            put_byte(to_query, at + i, wl_char_t'("a" + rand_below(3)));
        end
        put_byte(to_query, at + len, 8'h00);
    endtask

    task automatic build_vocab(input int target);
        int len;
        n_entries = 0;
        vend      = 0;
        while (vend + 8 <= target) begin
            if (rand_below(5) == 0) begin
                put_byte(1'b0, vend, 8'h00);
                vend++;
            end else begin
                entry_start[n_entries] = vend;
                n_entries++;
                put_word(1'b0, vend, len);
                vend += len + 1;
            end
        end
    endtask

    // kind 0 copies an entry, 1 a prefix, 2 an extension, 3 a random word, 4 empty
    task automatic make_query(input int kind);
        int src;
        int len;
        qstart = rand_below(200);
        if (kind == 4) begin
            put_byte(1'b1, qstart, 8'h00);
        end else if (kind == 3 || n_entries == 0) begin
            put_word(1'b1, qstart, len);
        end else begin
            src = entry_start[rand_below(n_entries)];
            len = 0;
            while (vocab_img[src + len] != 8'h00) begin
                len++;
            end
            if (kind == 1 && len > 1) begin
                len--;
            end
            for (int i = 0; i < len; i++) begin
                put_byte(1'b1, qstart + i, vocab_img[src + i]);
            end
            if (kind == 2) begin
                put_byte(1'b1, qstart + len, "c");
                len++;
            end
            put_byte(1'b1, qstart + len, 8'h00);
        end
    endtask

    task automatic start_search();
        write_reg(`WL_REG_VOCAB_END, vend);
        write_reg(`WL_REG_INPUT_START, qstart);
        write_reg(`WL_REG_CTRL, 32'h2);
        write_reg(`WL_REG_CTRL, 32'h1);
    endtask

    task automatic finish_search();
        do begin
            axi_read(`WL_REG_STATUS, got_status);
        end while (got_status[1] == 1'b0 && got_status[3] == 1'b0);
        axi_read(`WL_REG_MATCH_ADDR, got_maddr);
        axi_read(`WL_REG_CYCLES, got_cycles);
    endtask

    task automatic publish(input string label, input bit expect_error);
        exp_found = word_lookup_ref(vocab_img, vend, query_img, qstart, exp_addr);
        exp_error = expect_error;
        cur_label = label;
        -> result_ready;
        @(compare_done);
    endtask

    task automatic search_and_check(input string label);
        start_search();
        finish_search();
        publish(label, 1'b0);
    endtask

    initial begin
        forever begin
            @(result_ready);
            if (exp_error) begin
                expect_eq({cur_label, " status"}, got_status, 32'h8);
                expect_eq({cur_label, " cycles"}, got_cycles, cur_limit);
            end else begin
                expect_eq({cur_label, " status"}, got_status, {28'd0, 1'b0, exp_found, 2'b10});
                if (exp_found) begin
                    expect_eq({cur_label, " match_addr"}, got_maddr, exp_addr);
                end
                checks++;
                assert (got_cycles != 0 && got_cycles <= cur_limit) else begin
                    $display("ERROR %0t: %s cycles %0d outside 1..%0d", $time, cur_label,
                             got_cycles, cur_limit);
                    value_errors++;
                end
            end
            -> compare_done;
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, a bus transfer or a scan never finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] val;
        logic [1:0]  resp;
        int          target;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        checks       = 0;
        value_errors = 0;
        resp_errors  = 0;
        cur_limit    = 32'(`WL_DEFAULT_LIMIT);
        for (int i = 0; i < 256; i++) begin
            vocab_img[i] = 8'h00;
            query_img[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        axi_read(`WL_REG_STATUS, val);
        expect_eq("status after reset", val, 32'h0);
        axi_read(`WL_REG_LIMIT, val);
        expect_eq("limit after reset", val, 32'(`WL_DEFAULT_LIMIT));

        for (int t = 0; t < 5; t++) begin
            build_vocab(24 + rand_below(60));
            make_query(0);
            search_and_check($sformatf("copy %0d", t));
        end

        // one empty entry sits in front of cab
        load_str(1'b0, "abc.bca..cab.", 0);
        load_str(1'b1, "ab.", 40);
        search_and_check("prefix");
        load_str(1'b1, "abca.", 40);
        search_and_check("extension");
        load_str(1'b1, ".", 40);
        search_and_check("empty query");
        load_str(1'b1, "cab.", 40);
        search_and_check("after empty entry");

        for (int t = 0; t < 40; t++) begin
            build_vocab(16 + rand_below(100));
            if (rand_below(4) == 0) begin
                // end inside the last entry
                vend = vend - rand_below(3);
            end
            make_query(rand_below(5));
            search_and_check($sformatf("random %0d", t));
        end

        build_vocab(200);
        load_str(1'b1, "ccccccc.", 0);
        write_reg(`WL_REG_LIMIT, 32'd5);
        cur_limit = 32'd5;
        start_search();
        finish_search();
        publish("cycle limit", 1'b1);
        write_reg(`WL_REG_CTRL, 32'h2);
        axi_read(`WL_REG_STATUS, val);
        expect_eq("status after clear", val, 32'h0);
        write_reg(`WL_REG_LIMIT, 32'(`WL_DEFAULT_LIMIT));
        cur_limit = 32'(`WL_DEFAULT_LIMIT);

        // d never appears in random words, so dab is unique
        build_vocab(200);
        target = vend;
        load_str(1'b0, "dab.", target);
        load_str(1'b1, "ccccccc.", 0);
        start_search();
        axi_write(win_addr(`WL_VOCAB_BASE, target), 32'h61, resp);
        check_resp("window write while busy", resp, 2'b10);
        finish_search();
        publish("busy write scan", 1'b0);
        load_str(1'b1, "dab.", 0);
        search_and_check("memory unchanged");

        $display("checks %0d, value errors %0d, response errors %0d",
                 checks, value_errors, resp_errors);
        if (value_errors == 0 && resp_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: word_lookup.f
+incdir+design
design/word_lookup_pkg.sv
design/word_ram.sv
design/scan_timer.sv
design/match_fsm.sv
design/axil_regs.sv
design/word_lookup_top.sv
testbench/tb_word_lookup.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps
TOP       := tb_word_lookup
RTL_TOP   := word_lookup_top
FILELIST  := word_lookup.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
